// ==== logic/pmaAddrPkg.sv ====
package pmaAddrPkg;

  // Bit positions follow the 36-bit word numbering, bit 0 is the MSB
  localparam int PaLsb = 14;        // First physical address bit
  localparam int PaMsb = 35;
  localparam int PageMsb = 26;      // Last bit of the page number
  localparam int LineLsb = 27;      // First bit of the word within page
  localparam int RefillLsb = 18;    // VMA bits 18 to 26 index the page table on refill
  localparam int AdrParMsb = 33;    // Address parity stops short of bits 34 to 35

  // Physical address driven to the memory box
  typedef logic [PaLsb:PaMsb] physAddrT;

  // Page number part of an address
  typedef logic [PaLsb:PageMsb] pageNumT;

  // Word within the page
  typedef logic [LineLsb:PaMsb] lineT;

  // Virtual address as it arrives from the VMA register
  typedef logic [PaLsb:PaMsb] virtAddrT;

  // Refill offset taken from VMA bits 18 to 26
  typedef logic [RefillLsb:PageMsb] refillOffT;

endpackage

// ==== logic/pmaCyclePkg.sv ====
package pmaCyclePkg;

  // Source that feeds the physical address for the current cycle
  typedef enum logic [2:0] {
    srcUnpaged = 3'd0,  // VMA straight through
    srcPaged   = 3'd1,  // Page table page plus VMA line
    srcRefill  = 3'd2,  // Base register plus VMA bits 18 to 26
    srcSweep   = 3'd3,
    srcChannel = 3'd4,
    srcEra     = 3'd5   // Replay of the error address
  } addrSrcT;

  // Cache sweep counter state
  typedef enum logic {
    sweepIdle = 1'b0,
    sweepBusy = 1'b1
  } sweepStateT;

  // Cycle type flags, index 0 is page refill
  localparam int FlagRefill = 0;
  localparam int FlagEbox = 1;
  localparam int FlagWriteback = 2;
  localparam int NumFlags = 3;

  typedef logic [0:NumFlags-1] cycFlagsT;

endpackage

// ==== logic/pmaBaseRegs.sv ====
module pmaBaseRegs (
  input  logic                clock,
  input  logic                reset,
  input  logic                loadReg,
  input  logic                selUbr,
  input  logic                selEbr,
  input  logic                vmaUser,
  input  pmaAddrPkg::pageNumT vmaPage,
  output pmaAddrPkg::pageNumT refillBase
);

  import pmaAddrPkg::*;

  pageNumT ubr;  // User base page
  pageNumT ebr;  // Executive base page

  always_ff @(posedge clock) begin
    if (reset) begin
      ubr <= '0;
    end else if (loadReg && selUbr) begin
      ubr <= vmaPage;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      ebr <= '0;
    end else if (loadReg && selEbr) begin
      ebr <= vmaPage;
    end
  end

  // Refills use the user table in user mode
  assign refillBase = vmaUser ? ubr : ebr;

  // Microcode selects exactly one base register per load
  baseSelOneHot: assert property (
    @(posedge clock) disable iff (reset)
    loadReg |-> !(selUbr && selEbr)
  );

endmodule

// ==== logic/pmaSweepCounter.sv ====
module pmaSweepCounter #(
  parameter int SweepLines = 512
) (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 ccaLoad,
  input  logic                 ccaAdvance,
  input  pmaAddrPkg::pageNumT  vmaPage,
  output pmaAddrPkg::physAddrT sweepAddr,
  output logic                 ccaDone
);

  import pmaAddrPkg::*;
  import pmaCyclePkg::*;

  sweepStateT state;
  pageNumT    sweepPage;
  lineT       sweepLine;
  logic       lastLine;

  assign lastLine = (sweepLine == '0);

  // Page and line are payload, only the FSM and done flag reset
  always_ff @(posedge clock) begin
    if (ccaLoad) begin
      sweepPage <= vmaPage;
      sweepLine <= lineT'(SweepLines - 1);  // Sweep runs from the top line down
    end else if (ccaAdvance && state == sweepBusy && !lastLine) begin
      sweepLine <= sweepLine - 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= sweepIdle;
      ccaDone <= 1'b0;
    end else begin
      ccaDone <= 1'b0;
      case (state)
        sweepIdle: begin
          if (ccaLoad) begin
            state <= sweepBusy;
          end
        end
        sweepBusy: begin
          if (ccaLoad) begin
            state <= sweepBusy;             // Reload restarts the sweep
          end else if (ccaAdvance && lastLine) begin
            state   <= sweepIdle;
            ccaDone <= 1'b1;                // One-cycle completion pulse
          end
        end
        default: state <= sweepIdle;
      endcase
    end
  end

  assign sweepAddr = {sweepPage, sweepLine};

  sweepLineRange: assert property (
    @(posedge clock) disable iff (reset)
    state == sweepBusy |-> sweepLine <= SweepLines - 1
  );

endmodule

// ==== logic/pmaCycleSelect.sv ====
module pmaCycleSelect (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 readyToGo,
  input  logic                 eraGrant,
  input  logic                 pageRefill,
  input  logic                 chanGrant,
  input  logic                 ccaGrant,
  input  logic                 eboxGrant,
  input  logic                 eboxPaged,
  input  logic                 writeback,
  output pmaCyclePkg::addrSrcT addrSrc,
  output pmaCyclePkg::cycFlagsT cycFlags
);

  import pmaCyclePkg::*;

  addrSrcT  nextSrc;
  cycFlagsT nextFlags;

  // Fixed priority, ERA replay beats everything
  always_comb begin
    nextSrc = srcUnpaged;
    nextFlags = '0;
    if (eraGrant) begin
      nextSrc = srcEra;
    end else if (pageRefill) begin
      nextSrc = srcRefill;
      nextFlags[FlagRefill] = 1'b1;
    end else if (chanGrant) begin
      nextSrc = srcChannel;
    end else if (ccaGrant) begin
      nextSrc = srcSweep;
    end else if (eboxGrant) begin
      nextSrc = eboxPaged ? srcPaged : srcUnpaged;
      nextFlags[FlagEbox] = 1'b1;
    end
    nextFlags[FlagWriteback] = writeback;
  end

  // Source and cycle type hold between readyToGo pulses
  always_ff @(posedge clock) begin
    if (reset) begin
      addrSrc  <= srcUnpaged;
      cycFlags <= '0;
    end else if (readyToGo) begin
      addrSrc  <= nextSrc;
      cycFlags <= nextFlags;
    end
  end

  addrSrcKnown: assert property (
    @(posedge clock) disable iff (reset)
    !$isunknown(addrSrc)
  );

endmodule

// ==== logic/pmaAddrMux.sv ====
module pmaAddrMux (
  input  logic                 clock,
  input  logic                 reset,
  input  logic                 holdEra,
  input  pmaCyclePkg::addrSrcT addrSrc,
  input  pmaAddrPkg::virtAddrT vma,
  input  pmaAddrPkg::pageNumT  refillBase,
  input  pmaAddrPkg::pageNumT  ptPage,
  input  pmaAddrPkg::physAddrT sweepAddr,
  input  pmaAddrPkg::physAddrT chanAddr,
  output pmaAddrPkg::physAddrT pa,
  output pmaAddrPkg::physAddrT era,
  output logic                 adrPar,
  output logic                 pagePar
);

  import pmaAddrPkg::*;
  import pmaCyclePkg::*;

  lineT      vmaLine;
  refillOffT refillOff;

  assign vmaLine = vma[LineLsb:PaMsb];
  assign refillOff = vma[RefillLsb:PageMsb];

  always_comb begin
    case (addrSrc)
      srcUnpaged: pa = vma;
      srcPaged:   pa = {ptPage, vmaLine};
      srcRefill:  pa = {refillBase, refillOff};  // Page table entry address
      srcSweep:   pa = sweepAddr;
      srcChannel: pa = chanAddr;
      srcEra:     pa = era;
      default:    pa = vma;
    endcase
  end

  // Odd parity over 14 to 33
  assign adrPar = ~^pa[PaLsb:AdrParMsb];
  assign pagePar = ^pa[PaLsb:PageMsb];

  // Tracks every address until the error logic freezes it
  always_ff @(posedge clock) begin
    if (reset) begin
      era <= '0;
    end else if (!holdEra) begin
      era <= pa;
    end
  end

endmodule

// ==== logic/pma.sv ====
module pma #(
  parameter int SweepLines = 512
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  loadReg,
  input  logic                  selUbr,
  input  logic                  selEbr,
  input  logic                  vmaUser,
  input  pmaAddrPkg::virtAddrT  vma,
  input  logic                  ccaLoad,
  input  logic                  ccaAdvance,
  input  logic                  readyToGo,
  input  logic                  eraGrant,
  input  logic                  pageRefill,
  input  logic                  chanGrant,
  input  logic                  ccaGrant,
  input  logic                  eboxGrant,
  input  logic                  eboxPaged,
  input  logic                  writeback,
  input  logic                  holdEra,
  input  pmaAddrPkg::pageNumT   ptPage,
  input  pmaAddrPkg::physAddrT  chanAddr,
  output pmaAddrPkg::physAddrT  pa,
  output pmaAddrPkg::physAddrT  era,
  output logic                  adrPar,
  output logic                  pagePar,
  output logic                  ccaDone,
  output pmaCyclePkg::cycFlagsT cycFlags
);

  import pmaAddrPkg::*;
  import pmaCyclePkg::*;

  pageNumT  refillBase;
  physAddrT sweepAddr;
  addrSrcT  addrSrc;

  pmaBaseRegs baseRegs_i (
    .clock(clock), .reset(reset), .loadReg(loadReg),
    .selUbr(selUbr), .selEbr(selEbr), .vmaUser(vmaUser),
    .vmaPage(vma[PaLsb:PageMsb]), .refillBase(refillBase)
  );

  pmaSweepCounter #(.SweepLines(SweepLines)) sweep_i (
    .clock(clock), .reset(reset), .ccaLoad(ccaLoad), .ccaAdvance(ccaAdvance),
    .vmaPage(vma[PaLsb:PageMsb]), .sweepAddr(sweepAddr), .ccaDone(ccaDone)
  );

  pmaCycleSelect cycSel_i (
    .clock(clock), .reset(reset), .readyToGo(readyToGo),
    .eraGrant(eraGrant), .pageRefill(pageRefill), .chanGrant(chanGrant),
    .ccaGrant(ccaGrant), .eboxGrant(eboxGrant), .eboxPaged(eboxPaged),
    .writeback(writeback), .addrSrc(addrSrc), .cycFlags(cycFlags)
  );

  pmaAddrMux addrMux_i (
    .clock(clock), .reset(reset), .holdEra(holdEra), .addrSrc(addrSrc),
    .vma(vma), .refillBase(refillBase), .ptPage(ptPage),
    .sweepAddr(sweepAddr), .chanAddr(chanAddr),
    .pa(pa), .era(era), .adrPar(adrPar), .pagePar(pagePar)
  );

endmodule

// ==== tests/pmaTb.sv ====
module pmaTb;

  localparam int SweepLines = 512;
  localparam int DoneTimeout = 16;  // Cycles allowed for ccaDone to show up

  logic clock, reset;
  logic loadReg, selUbr, selEbr, vmaUser;
  logic ccaLoad, ccaAdvance, readyToGo, holdEra, writeback;
  logic eraGrant, pageRefill, chanGrant, ccaGrant, eboxGrant, eboxPaged;
  logic [14:35] vma, chanAddr, pa, era;
  logic [14:26] ptPage;
  logic adrPar, pagePar, ccaDone;
  logic [0:2] cycFlags;  // Refill, ebox, writeback

  int errCount, testCount, failedTests, testStartErrs;
  logic [14:26] ubrVal, ebrVal;

  pma #(.SweepLines(SweepLines)) dut_i (.*);

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  task automatic step;
    @(posedge clock);
    #1;
  endtask

  task automatic settle;
    #2;
  endtask

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errCount++;
    end
  endtask

  // Odd parity over bits 14 to 33
  function automatic logic addrParity(input logic [14:35] a);
    logic x;
    x = 1'b0;
    for (int i = 14; i <= 33; i++) x ^= a[i];
    return ~x;
  endfunction

  function automatic logic pageParity(input logic [14:35] a);
    logic x;
    x = 1'b0;
    for (int i = 14; i <= 26; i++) x ^= a[i];
    return x;
  endfunction

  task automatic checkAddr(input logic [14:35] exp);
    checkVal("pa", 32'(pa), 32'(exp));
    checkVal("adrPar", 32'(adrPar), 32'(addrParity(exp)));
    checkVal("pagePar", 32'(pagePar), 32'(pageParity(exp)));
  endtask

  task automatic checkFlags(input logic [0:2] exp);
    checkVal("cycFlags", 32'(cycFlags), 32'(exp));
  endtask

  // One readyToGo pulse with the given grants, grants dropped afterwards
  task automatic issueCycle(input logic eraG, input logic refillG, input logic chanG,
                            input logic ccaG, input logic eboxG, input logic paged);
    step;
    eraGrant = eraG;
    pageRefill = refillG;
    chanGrant = chanG;
    ccaGrant = ccaG;
    eboxGrant = eboxG;
    eboxPaged = paged;
    readyToGo = 1'b1;
    step;
    readyToGo = 1'b0;
    {eraGrant, pageRefill, chanGrant, ccaGrant, eboxGrant, eboxPaged} = '0;
  endtask

  task automatic startTest;
    testStartErrs = errCount;
  endtask

  task automatic endTest(input string name);
    testCount++;
    if (errCount != testStartErrs) begin
      failedTests++;
      $display("%s: FAIL (%0d errors)", name, errCount - testStartErrs);
    end else begin
      $display("%s: PASS", name);
    end
  endtask

  task automatic testUnpagedPaged;
    startTest();
    step;
    vma = 22'($urandom);
    ptPage = 13'($urandom);
    settle;
    checkAddr(vma);  // Unpaged after reset
    issueCycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b1);
    settle;
    checkAddr({ptPage, vma[27:35]});
    checkFlags(3'b010);
    step;
    vma = 22'($urandom);  // Paged address follows vma in the same cycle
    settle;
    checkAddr({ptPage, vma[27:35]});
    issueCycle(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);  // No grant falls back to vma
    settle;
    checkAddr(vma);
    checkFlags(3'b000);
    endTest("unpaged and paged");
  endtask

  task automatic testBaseRefill;
    startTest();
    step;
    ubrVal = 13'($urandom);
    vma = {ubrVal, 9'($urandom)};
    loadReg = 1'b1;
    selUbr = 1'b1;
    step;
    ebrVal = 13'($urandom);
    vma = {ebrVal, 9'($urandom)};
    selUbr = 1'b0;
    selEbr = 1'b1;
    step;
    loadReg = 1'b0;
    selEbr = 1'b0;
    vma = 22'($urandom);
    vmaUser = 1'b1;
    issueCycle(1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0);
    settle;
    checkAddr({ubrVal, vma[18:26]});
    checkFlags(3'b100);
    step;
    vmaUser = 1'b0;
    settle;
    checkAddr({ebrVal, vma[18:26]});
    endTest("base registers and refill");
  endtask

  task automatic testPriority;
    logic [14:35] x;
    startTest();
    step;
    x = 22'($urandom);
    chanAddr = x;
    writeback = 1'b1;
    issueCycle(1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b0);  // Channel beats sweep and ebox
    settle;
    checkAddr(x);
    checkFlags(3'b001);
    step;
    pageRefill = 1'b1;  // No readyToGo, so nothing may move
    eboxGrant = 1'b1;
    writeback = 1'b0;
    step;
    step;
    settle;
    checkAddr(x);
    checkFlags(3'b001);
    step;
    pageRefill = 1'b0;
    eboxGrant = 1'b0;
    holdEra = 1'b1;
    settle;
    checkVal("era", 32'(era), 32'(x));
    step;
    chanAddr = ~x;
    issueCycle(1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0);  // ERA over refill and channel
    settle;
    checkAddr(x);
    checkFlags(3'b000);
    issueCycle(1'b0, 1'b1, 1'b1, 1'b1, 1'b0, 1'b0);
    settle;
    checkAddr({ebrVal, vma[18:26]});  // Executive mode since the refill test
    checkFlags(3'b100);
    step;
    holdEra = 1'b0;
    endTest("grant priority and hold");
  endtask

  task automatic testSweep;
    logic [14:26] page;
    logic [27:35] line;
    int waitCycles;
    startTest();
    step;
    page = 13'($urandom);
    vma = {page, 9'($urandom)};
    ccaLoad = 1'b1;
    step;
    ccaLoad = 1'b0;
    issueCycle(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0);
    line = 9'(SweepLines - 1);
    settle;
    checkAddr({page, line});
    step;
    ccaAdvance = 1'b1;
    repeat (SweepLines - 1) begin
      step;
      line = line - 1'b1;
      settle;
      checkAddr({page, line});
      checkVal("ccaDone", 32'(ccaDone), 32'(0));
    end
    step;  // Advance at line 0 ends the sweep
    ccaAdvance = 1'b0;
    waitCycles = 0;
    settle;
    while (!ccaDone && waitCycles < DoneTimeout) begin
      step;
      settle;
      waitCycles++;
    end
    assert (ccaDone) else begin
      $display("ccaDone never pulsed within %0d cycles of the last advance", DoneTimeout);
      errCount++;
    end
    step;
    settle;
    checkVal("ccaDone", 32'(ccaDone), 32'(0));
    step;
    ccaAdvance = 1'b1;  // Idle counter ignores these
    repeat (3) begin
      step;
      settle;
      checkAddr({page, line});
      checkVal("ccaDone", 32'(ccaDone), 32'(0));
    end
    step;
    ccaAdvance = 1'b0;
    endTest("cache sweep");
  endtask

  task automatic testEra;
    logic [14:35] a;
    logic [14:35] b;
    startTest();
    step;
    a = 22'($urandom);
    chanAddr = a;
    issueCycle(1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);
    settle;
    checkAddr(a);
    step;
    b = 22'($urandom);
    chanAddr = b;
    settle;
    checkVal("era", 32'(era), 32'(a));
    checkAddr(b);
    step;
    holdEra = 1'b1;
    chanAddr = ~b;
    settle;
    checkVal("era", 32'(era), 32'(b));
    checkAddr(~b);
    step;
    settle;
    checkVal("era", 32'(era), 32'(b));  // Frozen while pa differs
    issueCycle(1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
    settle;
    checkAddr(b);
    step;
    holdEra = 1'b0;
    endTest("error address register");
  endtask

  initial begin
    void'($urandom(91));
    {loadReg, selUbr, selEbr, vmaUser, ccaLoad, ccaAdvance, readyToGo} = '0;
    {holdEra, writeback, eraGrant, pageRefill, chanGrant, ccaGrant} = '0;
    {eboxGrant, eboxPaged} = '0;
    vma = '0;
    chanAddr = '0;
    ptPage = '0;
    ubrVal = '0;
    ebrVal = '0;
    errCount = 0;
    testCount = 0;
    failedTests = 0;
    reset = 1'b1;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    testUnpagedPaged();
    testBaseRefill();
    testPriority();
    testSweep();
    testEra();

    $display("Tests run: %0d, tests failed: %0d, check errors: %0d",
             testCount, failedTests, errCount);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== flist.f ====
logic/pmaAddrPkg.sv
logic/pmaCyclePkg.sv
logic/pmaBaseRegs.sv
logic/pmaSweepCounter.sv
logic/pmaCycleSelect.sv
logic/pmaAddrMux.sv
logic/pma.sv
tests/pmaTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module pmaTb -f flist.f -o pmaSim

./obj_dir/pmaSim | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "Simulation FAILED"
  exit 1
fi

echo "Simulation PASSED"
